//--- src/fetch_pkg.sv
/*
 * Sizes shared by the fetch front end: address and instruction widths,
 * instruction store depth and the address fetched first after reset.
 */

package fetch_pkg;

  // --------------------
  // Datapath widths
  // --------------------

  // Program counter and branch target
  localparam int ADDR_BITS = 32;

  // One RV32 instruction word, no compressed forms
  localparam int INST_BITS = 32;

  // --------------------
  // Instruction store
  // --------------------

  // Word count, kept a power of two
  localparam int STORE_WORDS    = 64;
  localparam int STORE_IDX_BITS = 6;

  // --------------------
  // Reset
  // --------------------

  // First fetch address once rst drops
  localparam logic [ADDR_BITS-1:0] RESET_PC = 32'h0000_0000;

endpackage

//--- src/rv32_isa_pkg.sv
/*
 * RV32 encoding details for decode: the major opcode class enum, the
 * 7-bit opcode field values, field positions and immediate builders.
 */

package rv32_isa_pkg;

  // --------------------
  // Opcode classes
  // --------------------

  typedef enum logic [3:0] {
    OP_LUI     = 4'd0,
    OP_AUIPC   = 4'd1,
    OP_JAL     = 4'd2,
    OP_JALR    = 4'd3,
    OP_BRANCH  = 4'd4,
    OP_LOAD    = 4'd5,
    OP_STORE   = 4'd6,
    OP_IMM     = 4'd7,
    OP_REG     = 4'd8,
    OP_SYSTEM  = 4'd9,
    OP_ILLEGAL = 4'd15
  } opcode_e;

  // Major opcode field values, inst[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // --------------------
  // Field positions
  // --------------------

  localparam int OPCODE_MSB = 6;
  localparam int RD_LSB     = 7;
  localparam int RD_MSB     = 11;

  // --------------------
  // Immediate formats
  // --------------------

  // Loads, ALU immediates, JALR, SYSTEM
  function automatic logic [31:0] imm_i(input logic [31:0] inst);
    return {{20{inst[31]}}, inst[31:20]};
  endfunction

  // Stores, split across two fields
  function automatic logic [31:0] imm_s(input logic [31:0] inst);
    return {{20{inst[31]}}, inst[31:25], inst[11:7]};
  endfunction

  // Branches, halfword offset
  function automatic logic [31:0] imm_b(input logic [31:0] inst);
    return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

  // LUI and AUIPC, upper 20 bits
  function automatic logic [31:0] imm_u(input logic [31:0] inst);
    return {inst[31:12], 12'b0};
  endfunction

  // JAL, 21-bit halfword offset
  function automatic logic [31:0] imm_j(input logic [31:0] inst);
    return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

endpackage

//--- src/inst_store.sv
/*
 * Word-addressed instruction store with a registered read port.
 * Loaded from outside while the front end sits in reset; each word
 * carries a valid bit so fetch can tell loaded from empty locations.
 */

`timescale 1ns/1ps

module inst_store import fetch_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      store_clear,
  input  logic                      load_en,
  input  logic [STORE_IDX_BITS-1:0] load_idx,
  input  logic [INST_BITS-1:0]      load_data,
  input  logic [ADDR_BITS-1:0]      rd_addr,
  output logic [INST_BITS-1:0]      rd_data,
  output logic                      rd_hit
);

  logic [INST_BITS-1:0]      mem [STORE_WORDS];
  logic [STORE_WORDS-1:0]    word_valid;
  logic [STORE_IDX_BITS-1:0] rd_idx;
  logic                      rd_in_range;

  // Byte address to word index, upper bits must be zero
  assign rd_idx      = rd_addr[STORE_IDX_BITS+1:2];
  assign rd_in_range = (rd_addr[ADDR_BITS-1:STORE_IDX_BITS+2] == '0);

  // --------------------
  // Load side
  // --------------------

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_idx] <= load_data;
    end
  end

  // Valid bits survive rst, the program is loaded during it
  always_ff @(posedge clk) begin
    if (store_clear) begin
      word_valid <= '0;
    end else if (load_en) begin
      word_valid[load_idx] <= 1'b1;
    end
  end

  // --------------------
  // Read side
  // --------------------

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_idx];
  end

  // Hit only for a loaded word inside the store
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_hit <= 1'b0;
    end else begin
      rd_hit <= rd_in_range && word_valid[rd_idx];
    end
  end

  // Program may change only while the front end is held
  a_load_in_reset: assert property (@(posedge clk) (load_en || store_clear) |-> rst);

  // Fetch never produces a misaligned address
  a_rd_aligned: assert property (@(posedge clk) disable iff (rst) rd_addr[1:0] == 2'b00);

endmodule

//--- src/fetch_unit.sv
/*
 * Fetch stage: owns the program counter, reads the instruction store and
 * presents pc/inst to decode under a val/rdy handshake. A squash from
 * decode kills the word on show and restarts fetch at branch_target.
 */

`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,

  // Decode side
  input  logic                 rdy,
  input  logic                 squash,
  input  logic [ADDR_BITS-1:0] branch_target,

  // Store read port
  input  logic [INST_BITS-1:0] rd_data,
  input  logic                 rd_hit,
  output logic [ADDR_BITS-1:0] rd_addr,

  // Presentation to decode
  output logic                 val,
  output logic [ADDR_BITS-1:0] pc,
  output logic [INST_BITS-1:0] inst
);

  logic                 xfer;
  logic [ADDR_BITS-1:0] next_pc;

  // --------------------
  // Handshake
  // --------------------

  // Word on show is the store's answer for pc
  // Wrong-path word killed during squash
  assign val  = rd_hit && !squash;
  assign inst = rd_data;

  // Decode takes the word this cycle
  assign xfer = val && rdy && !squash;

  // --------------------
  // Next pc
  // --------------------

  // Redirect beats sequential advance
  // No transfer means hold, store re-reads the same word
  always_comb begin
    if (squash) begin
      next_pc = branch_target;
    end else if (xfer) begin
      next_pc = pc + ADDR_BITS'(4);
    end else begin
      next_pc = pc;
    end
  end

  // Store reads next pc now, so data lines up with pc next cycle
  assign rd_addr = next_pc;

  // --------------------
  // PC register
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Offered word holds under back-pressure
  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst)
    (val && !rdy && !squash) |=> ($stable(pc) && $stable(inst))
  );

  // Decode only ever redirects to a word boundary
  a_target_aligned: assert property (
    @(posedge clk) disable iff (rst)
    squash |-> (branch_target[1:0] == 2'b00)
  );

endmodule

//--- src/decode_unit.sv
/*
 * Decode stage: accepts one instruction per transfer, classifies the
 * major opcode, extracts rd and the format immediate, and emits one
 * out_val pulse per instruction. JAL is resolved here via squash.
 */

`timescale 1ns/1ps

module decode_unit import fetch_pkg::*, rv32_isa_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,

  // From fetch
  input  logic                 val,
  input  logic [ADDR_BITS-1:0] pc,
  input  logic [INST_BITS-1:0] inst,
  output logic                 rdy,

  // Redirect back to fetch
  output logic                 squash,
  output logic [ADDR_BITS-1:0] branch_target,

  // Decoded stream, no back-pressure
  output logic                 out_val,
  output logic [ADDR_BITS-1:0] out_pc,
  output opcode_e              out_op,
  output logic [4:0]           out_rd,
  output logic [31:0]          out_imm
);

  logic        xfer;
  opcode_e     dec_op;
  logic [4:0]  dec_rd;
  logic [31:0] dec_imm;

  // --------------------
  // Handshake
  // --------------------

  // Refuse the wrong-path word while squash is up
  assign rdy  = !stall && !squash;
  assign xfer = val && rdy;

  // --------------------
  // Opcode and fields
  // --------------------

  always_comb begin
    dec_rd = inst[RD_MSB:RD_LSB];
    case (inst[OPCODE_MSB:0])
      OPC_LUI: begin
        dec_op  = OP_LUI;
        dec_imm = imm_u(inst);
      end
      OPC_AUIPC: begin
        dec_op  = OP_AUIPC;
        dec_imm = imm_u(inst);
      end
      OPC_JAL: begin
        dec_op  = OP_JAL;
        dec_imm = imm_j(inst);
      end
      OPC_JALR: begin
        dec_op  = OP_JALR;
        dec_imm = imm_i(inst);
      end
      // Branch and store write no register
      OPC_BRANCH: begin
        dec_op  = OP_BRANCH;
        dec_rd  = 5'd0;
        dec_imm = imm_b(inst);
      end
      OPC_STORE: begin
        dec_op  = OP_STORE;
        dec_rd  = 5'd0;
        dec_imm = imm_s(inst);
      end
      OPC_LOAD: begin
        dec_op  = OP_LOAD;
        dec_imm = imm_i(inst);
      end
      OPC_IMM: begin
        dec_op  = OP_IMM;
        dec_imm = imm_i(inst);
      end
      // R-type has no immediate
      OPC_REG: begin
        dec_op  = OP_REG;
        dec_imm = 32'd0;
      end
      OPC_SYSTEM: begin
        dec_op  = OP_SYSTEM;
        dec_imm = imm_i(inst);
      end
      // Unknown word, no register and no immediate
      default: begin
        dec_op  = OP_ILLEGAL;
        dec_rd  = 5'd0;
        dec_imm = 32'd0;
      end
    endcase
  end

  // --------------------
  // Output registers
  // --------------------

  // One pulse per accepted word, squash along with a JAL
  always_ff @(posedge clk) begin
    if (rst) begin
      out_val <= 1'b0;
      squash  <= 1'b0;
    end else begin
      out_val <= xfer;
      squash  <= xfer && (dec_op == OP_JAL);
    end
  end

  // Payload, only meaningful under out_val / squash
  always_ff @(posedge clk) begin
    if (xfer) begin
      out_pc        <= pc;
      out_op        <= dec_op;
      out_rd        <= dec_rd;
      out_imm       <= dec_imm;
      branch_target <= pc + dec_imm;
    end
  end

  // Redirect is a single pulse per JAL
  a_squash_pulse: assert property (@(posedge clk) disable iff (rst) squash |=> !squash);

endmodule

//--- src/fetch_decode_top.sv
/*
 * Fetch/decode front end: instruction store, fetch and decode wired
 * together. Load the store under rst, then read the decoded stream.
 */

`timescale 1ns/1ps

module fetch_decode_top import fetch_pkg::*, rv32_isa_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stall,
  input  logic                      store_clear,
  input  logic                      load_en,
  input  logic [STORE_IDX_BITS-1:0] load_idx,
  input  logic [INST_BITS-1:0]      load_data,
  output logic                      out_val,
  output logic [ADDR_BITS-1:0]      out_pc,
  output opcode_e                   out_op,
  output logic [4:0]                out_rd,
  output logic [31:0]               out_imm
);

  // Store read port
  logic [ADDR_BITS-1:0] rd_addr;
  logic [INST_BITS-1:0] rd_data;
  logic                 rd_hit;

  // Fetch to decode
  logic                 val;
  logic                 rdy;
  logic [ADDR_BITS-1:0] pc;
  logic [INST_BITS-1:0] inst;

  // Redirect
  logic                 squash;
  logic [ADDR_BITS-1:0] branch_target;

  inst_store i_inst_store (
    .clk         (clk),
    .rst         (rst),
    .store_clear (store_clear),
    .load_en     (load_en),
    .load_idx    (load_idx),
    .load_data   (load_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .rd_hit      (rd_hit)
  );

  fetch_unit i_fetch_unit (
    .clk           (clk),
    .rst           (rst),
    .rdy           (rdy),
    .squash        (squash),
    .branch_target (branch_target),
    .rd_data       (rd_data),
    .rd_hit        (rd_hit),
    .rd_addr       (rd_addr),
    .val           (val),
    .pc            (pc),
    .inst          (inst)
  );

  decode_unit i_decode_unit (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .val           (val),
    .pc            (pc),
    .inst          (inst),
    .rdy           (rdy),
    .squash        (squash),
    .branch_target (branch_target),
    .out_val       (out_val),
    .out_pc        (out_pc),
    .out_op        (out_op),
    .out_rd        (out_rd),
    .out_imm       (out_imm)
  );

endmodule

//--- sim/fd_vectors.svh
/*
 * Test program and expected decoded stream for the front-end testbench.
 * Included inside the testbench module, after its package imports.
 */

`ifndef FD_VECTORS_SVH
`define FD_VECTORS_SVH

// Eleven loaded words, ten of them reach decode
localparam int PROG_LEN = 11;
localparam int EXP_LEN  = 10;

typedef struct {
  logic [STORE_IDX_BITS-1:0] idx;
  logic [INST_BITS-1:0]      word;
} prog_entry_t;

typedef struct {
  logic [ADDR_BITS-1:0] pc;
  opcode_e              op;
  logic [4:0]           rd;
  logic [31:0]          imm;
} exp_entry_t;

prog_entry_t prog_tab [PROG_LEN];
exp_entry_t  exp_tab  [EXP_LEN];

// --------------------
// Encoders
// --------------------

function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
  return {imm, rs1, 3'b000, rd, OPC_IMM};
endfunction

function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] imm);
  return {imm, rd, OPC_LUI};
endfunction

function automatic logic [31:0] add_word(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
  return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_REG};
endfunction

// Offset split across the funct7 and rd slots
function automatic logic [31:0] sw_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] beq_word(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] jal_word(logic [4:0] rd, logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// --------------------
// Tables
// --------------------

task automatic fill_tables();
  // Straight line, then forward jal from 0x10 to 0x28
  prog_tab[0]  = '{6'd0,  addi_word(5'd1, 5'd0, 12'd5)};
  prog_tab[1]  = '{6'd1,  addi_word(5'd2, 5'd0, -12'sd3)};
  prog_tab[2]  = '{6'd2,  lui_word(5'd3, 20'h12345)};
  prog_tab[3]  = '{6'd3,  add_word(5'd4, 5'd1, 5'd2)};
  prog_tab[4]  = '{6'd4,  jal_word(5'd5, 21'd24)};
  // Wrong path of the first jal, must never decode
  prog_tab[5]  = '{6'd5,  addi_word(5'd6, 5'd0, 12'd99)};
  // Block entered only by the backward jal
  prog_tab[6]  = '{6'd6,  sw_word(5'd2, 5'd1, -12'sd8)};
  prog_tab[7]  = '{6'd7,  beq_word(5'd1, 5'd2, -13'sd16)};
  // Opcode 0 with rd field set
  prog_tab[8]  = '{6'd8,  32'h0000_0f80};
  // Idx 9 left empty, fetch stops there
  prog_tab[9]  = '{6'd10, lui_word(5'd7, 20'hfffff)};
  prog_tab[10] = '{6'd11, jal_word(5'd1, -21'sd20)};

  exp_tab[0] = '{32'h0000_0000, OP_IMM,     5'd1, 32'd5};
  exp_tab[1] = '{32'h0000_0004, OP_IMM,     5'd2, 32'hffff_fffd};
  exp_tab[2] = '{32'h0000_0008, OP_LUI,     5'd3, 32'h1234_5000};
  exp_tab[3] = '{32'h0000_000c, OP_REG,     5'd4, 32'd0};
  exp_tab[4] = '{32'h0000_0010, OP_JAL,     5'd5, 32'd24};
  exp_tab[5] = '{32'h0000_0028, OP_LUI,     5'd7, 32'hffff_f000};
  exp_tab[6] = '{32'h0000_002c, OP_JAL,     5'd1, 32'hffff_ffec};
  exp_tab[7] = '{32'h0000_0018, OP_STORE,   5'd0, 32'hffff_fff8};
  exp_tab[8] = '{32'h0000_001c, OP_BRANCH,  5'd0, 32'hffff_fff0};
  exp_tab[9] = '{32'h0000_0020, OP_ILLEGAL, 5'd0, 32'd0};
endtask

`endif

//--- sim/fetch_decode_tb.sv
/*
 * Testbench for the fetch/decode front end. Loads a short program while
 * rst is high, then stalls decode at random and checks every decoded
 * instruction against the expected stream, in order.
 */

`timescale 1ns/1ps

module fetch_decode_tb import fetch_pkg::*, rv32_isa_pkg::*; ();

  `include "fd_vectors.svh"

  localparam int RESET_CYCLES   = 16;
  localparam int QUIET_CYCLES   = 20;
  localparam int TIMEOUT_CYCLES = 4 * EXP_LEN + PROG_LEN + 50;

  logic                      clk;
  logic                      rst;
  logic                      stall;
  logic                      store_clear;
  logic                      load_en;
  logic [STORE_IDX_BITS-1:0] load_idx;
  logic [INST_BITS-1:0]      load_data;
  logic                      out_val;
  logic [ADDR_BITS-1:0]      out_pc;
  opcode_e                   out_op;
  logic [4:0]                out_rd;
  logic [31:0]               out_imm;

  int          seen_count;
  int          run_cycles;
  logic [31:0] rng_state;

  fetch_decode_top i_fetch_decode_top (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .store_clear (store_clear),
    .load_en     (load_en),
    .load_idx    (load_idx),
    .load_data   (load_data),
    .out_val     (out_val),
    .out_pc      (out_pc),
    .out_op      (out_op),
    .out_rd      (out_rd),
    .out_imm     (out_imm)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // --------------------
  // Reset, load, finish
  // --------------------

  initial begin
    rst         = 1'b1;
    stall       = 1'b0;
    store_clear = 1'b0;
    load_en     = 1'b0;
    load_idx    = '0;
    load_data   = '0;
    rng_state   = 32'h4b70;
    seen_count  = 0;
    run_cycles  = 0;
    fill_tables();

    // Clear on the first edge and load one word per edge after that
    for (int cyc = 0; cyc < RESET_CYCLES; cyc++) begin
      @(posedge clk);
      store_clear <= (cyc == 0);
      if (cyc >= 1 && cyc <= PROG_LEN) begin
        load_en   <= 1'b1;
        load_idx  <= prog_tab[cyc-1].idx;
        load_data <= prog_tab[cyc-1].word;
      end else begin
        load_en <= 1'b0;
      end
      if (cyc == RESET_CYCLES - 1) begin
        rst <= 1'b0;
      end
    end

    // State right after the last reset edge
    @(negedge clk);
    compare_value("out_val", 32'(out_val), 32'd0);
    compare_value("val", 32'(i_fetch_decode_top.val), 32'd0);
    compare_value("squash", 32'(i_fetch_decode_top.squash), 32'd0);
    compare_value("pc", i_fetch_decode_top.pc, RESET_PC);

    while (seen_count < EXP_LEN) begin
      @(posedge clk);
    end

    // Fetch must stay parked on the empty word
    repeat (QUIET_CYCLES) @(negedge clk);
    @(posedge clk);
    $display("** PASS **");
    $finish;
  end

  // --------------------
  // Stall and timeout
  // --------------------

  // Roughly one cycle in three stalled
  always @(posedge clk) begin
    if (!rst) begin
      rng_state = xorshift32(rng_state);
      stall <= (rng_state % 3 == 0);
      run_cycles++;
      if (run_cycles > TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles with %0d of %0d instructions decoded",
                 run_cycles, seen_count, EXP_LEN);
        $display("** FAIL **");
        $fatal(1, "timeout");
      end
    end
  end

  // --------------------
  // Decoded stream check
  // --------------------

  // Sampled mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (!rst && out_val === 1'b1) begin
      if (seen_count >= EXP_LEN) begin
        $display("Extra instruction at pc %h after the expected stream ended", out_pc);
        $display("** FAIL **");
        $fatal(1, "extra decoded instruction");
      end else begin
        compare_value("out_pc", out_pc, exp_tab[seen_count].pc);
        compare_value("out_op", 32'(out_op), 32'(exp_tab[seen_count].op));
        compare_value("out_rd", 32'(out_rd), 32'(exp_tab[seen_count].rd));
        compare_value("out_imm", out_imm, exp_tab[seen_count].imm);
        seen_count++;
      end
    end
  end

endmodule

//--- compile.f
+incdir+sim
src/fetch_pkg.sv
src/rv32_isa_pkg.sv
src/inst_store.sv
src/fetch_unit.sv
src/decode_unit.sv
src/fetch_decode_top.sv
sim/fetch_decode_tb.sv
